/* common/frv_settings.svh */
/*
 * Core-wide constants for the reduced RV32 pipeline.
 * XLEN is fixed at one 32-bit word and is not meant to change.
 */
`ifndef FRV_SETTINGS_SVH
`define FRV_SETTINGS_SVH

`define FRV_XLEN     32             // Data and address width
`define FRV_PC_RESET 32'h0000_0000  // First fetch address
`define FRV_NREGS    32             // GPR count, x0 included

`endif

/* common/frv_pkg.sv */
/*
 * Shared types of the pipeline. Payload structs are packed so they can
 * be registered and compared as whole vectors.
 */
`include "frv_settings.svh"

package frv_pkg;

typedef logic [4:0]           reg_addr_t;  // GPR index
typedef logic [`FRV_XLEN-1:0] word_t;      // One data word

// Micro-op after decode
typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    LOAD,
    STORE,
    BR_EQ,
    BR_NE
} uop_e;

// ----------------------------------------
// Stage payloads

typedef struct packed {
    word_t     pc;
    word_t     instr;
} fetch_t;

typedef struct packed {
    word_t     pc;
    word_t     instr;
    uop_e      uop;
    reg_addr_t rd;          // Zero when nothing is written
    word_t     opr_a;       // rs1 or zero
    word_t     opr_b;       // rs2 or immediate
    word_t     opr_c;       // Store data or branch target
} decode_t;

typedef struct packed {
    word_t     pc;
    word_t     instr;
    uop_e      uop;
    reg_addr_t rd;
    word_t     result;      // ALU value, address or target
    word_t     store_data;
    logic      taken;       // Branch redirects
} exec_t;

// ----------------------------------------
// Side channels

typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     wdata;
    logic      is_load;     // Data not ready yet
} fwd_t;

typedef struct packed {
    logic      wen;
    logic [3:0] strb;
    word_t     addr;
    word_t     wdata;
} mem_req_t;

typedef struct packed {
    word_t     pc;
    word_t     instr;
    reg_addr_t rd;
    word_t     wdata;       // Zero when rd is x0
} trace_t;

endpackage

/* rtl/frv_gprs.sv */
/*
 * 32 x 32 register file, two asynchronous reads, one write.
 * x0 is not stored. Writes are ignored while in reset.
 */
`timescale 1ns/10ps
`include "frv_settings.svh"

module frv_gprs import frv_pkg::*; (
    input  logic      g_clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      rd_wen,
    input  reg_addr_t rd_addr,
    input  word_t     rd_wdata,
    output word_t     rs1_data,
    output word_t     rs2_data
);

word_t regs [1:`FRV_NREGS-1];       // x1..x31

always_ff @(posedge g_clk) begin
    if (!rst && rd_wen && |rd_addr) begin
        regs[rd_addr] <= rd_wdata;
    end
end

assign rs1_data = |rs1_addr ? regs[rs1_addr] : '0;  // x0 is hardwired
assign rs2_data = |rs2_addr ? regs[rs2_addr] : '0;

endmodule

/* rtl/frv_hazard.sv */
/*
 * Operand bypass from execute, memory and writeback into decode.
 * Any match against a stage holding a load stalls decode, even if a
 * younger stage would also have matched.
 */
`timescale 1ns/10ps

module frv_hazard import frv_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      s1_valid,
    input  logic      s2_busy,
    input  fwd_t      fwd_s2,
    input  fwd_t      fwd_s3,
    input  fwd_t      fwd_s4,
    output word_t     rs1_fwd,
    output word_t     rs2_fwd,
    output logic      s1_bubble
);

logic [2:0] hit1, hit2;             // Bit 0 execute, bit 2 writeback
logic [2:0] ld;                     // Stage holds a load

function automatic logic hit(reg_addr_t src, fwd_t f);
    return |src && f.valid && (f.rd == src);
endfunction

assign hit1 = {hit(rs1_addr, fwd_s4), hit(rs1_addr, fwd_s3), hit(rs1_addr, fwd_s2)};
assign hit2 = {hit(rs2_addr, fwd_s4), hit(rs2_addr, fwd_s3), hit(rs2_addr, fwd_s2)};
assign ld   = {fwd_s4.is_load, fwd_s3.is_load, fwd_s2.is_load};

// Youngest producer wins
assign rs1_fwd = hit1[0] ? fwd_s2.wdata :
                 hit1[1] ? fwd_s3.wdata :
                 hit1[2] ? fwd_s4.wdata : rs1_data;
assign rs2_fwd = hit2[0] ? fwd_s2.wdata :
                 hit2[1] ? fwd_s3.wdata :
                 hit2[2] ? fwd_s4.wdata : rs2_data;

assign s1_bubble = (!s1_valid && !s2_busy) ||     // Nothing to decode
                   |((hit1 | hit2) & ld);         // Load result not back yet

endmodule

/* pipeline/frv_fetch.sv */
/*
 * One outstanding instruction read at a time, plus a one-word buffer
 * while decode stalls. Redirects are only acknowledged with no read in
 * flight, so the request address never moves before gnt.
 */
`timescale 1ns/10ps
`include "frv_settings.svh"

module frv_fetch import frv_pkg::*; (
    input  logic     g_clk,
    input  logic     rst,
    input  logic     flush,
    input  word_t    cf_target,
    input  logic     s1_busy,
    input  logic     imem_gnt,
    input  word_t    imem_rdata,
    output logic     cf_ack,
    output logic     imem_req,
    output mem_req_t imem_out,
    output logic     s1_valid,
    output fetch_t   s1_data
);

logic   run;                        // Fetching enabled after reset
logic   pend;                       // Read data arrives this cycle
logic   buf_valid;                  // Word parked for decode
fetch_t buf_data;
word_t  pc;                         // Next address to request
logic   take;

assign take     = imem_req && imem_gnt;
assign imem_req = run && !buf_valid && !(pend && s1_busy);  // Room for the word
assign cf_ack   = !pend && !(imem_req && !imem_gnt);
assign imem_out = '{wen: 1'b0, strb: 4'hf, addr: pc, wdata: '0};

assign s1_valid = pend || buf_valid;
assign s1_data  = buf_valid ? buf_data : '{pc: pc - word_t'(4), instr: imem_rdata};

always_ff @(posedge g_clk) begin
    if (rst) begin
        run       <= 1'b0;
        pend      <= 1'b0;
        buf_valid <= 1'b0;
        pc        <= `FRV_PC_RESET;
    end else begin
        run  <= 1'b1;
        pend <= take && !flush;               // Word granted on redirect is dropped
        if (flush) begin
            buf_valid <= 1'b0;
            pc        <= cf_target;
        end else begin
            buf_valid <= s1_valid && s1_busy;
            if (take) pc <= pc + word_t'(4);
        end
    end
end

always_ff @(posedge g_clk) begin
    if (pend && s1_busy) buf_data <= s1_data;  // Park returned word
end

// Request held unchanged until granted, redirects included
assert property (@(posedge g_clk) disable iff (rst)
    imem_req && !imem_gnt |=> imem_req && $stable(imem_out.addr));

endmodule

/* pipeline/frv_decode.sv */
/*
 * Decodes the RV32 subset into micro-ops. Anything else, including
 * unsupported funct3 values, becomes ADDI x0 and retires as a nop.
 * Operands come already forwarded from the hazard unit.
 */
`timescale 1ns/10ps

module frv_decode import frv_pkg::*; (
    input  logic      g_clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      s1_valid,
    input  fetch_t    s1_data,
    input  logic      s1_bubble,
    input  word_t     rs1_fwd,
    input  word_t     rs2_fwd,
    input  logic      s2_busy,
    output logic      s1_busy,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      s2_valid,
    output decode_t   s2_data
);

word_t      instr;
logic [6:0] opcode;
logic [2:0] funct3;
reg_addr_t  rd_f;
word_t      imm_i, imm_s, imm_b, imm_u;
decode_t    dec;
logic       s2_stall;                 // Output register cannot move

assign instr    = s1_data.instr;
assign opcode   = instr[6:0];
assign funct3   = instr[14:12];
assign rd_f     = instr[11:7];
assign rs1_addr = instr[19:15];
assign rs2_addr = instr[24:20];

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
assign imm_u = {instr[31:12], 12'b0};

always_comb begin
    dec.pc    = s1_data.pc;
    dec.instr = instr;
    dec.uop   = ALU_ADD;
    dec.rd    = '0;                   // Nop unless matched below
    dec.opr_a = rs1_fwd;
    dec.opr_b = imm_i;
    dec.opr_c = rs2_fwd;              // Store data
    case (opcode)
        7'b0110011: begin             // Register ALU ops
            dec.opr_b = rs2_fwd;
            dec.rd    = rd_f;
            case (funct3)
                3'b000:  dec.uop = instr[30] ? ALU_SUB : ALU_ADD;
                3'b100:  dec.uop = ALU_XOR;
                3'b110:  dec.uop = ALU_OR;
                3'b111:  dec.uop = ALU_AND;
                default: dec.rd  = '0;
            endcase
        end
        7'b0010011: if (funct3 == 3'b000) dec.rd = rd_f;  // ADDI
        7'b0110111: begin             // LUI
            dec.opr_a = '0;
            dec.opr_b = imm_u;
            dec.rd    = rd_f;
        end
        7'b0000011: if (funct3 == 3'b010) begin  // LW
            dec.uop = LOAD;
            dec.rd  = rd_f;
        end
        7'b0100011: if (funct3 == 3'b010) begin  // SW
            dec.uop   = STORE;
            dec.opr_b = imm_s;
        end
        7'b1100011: if (funct3[2:1] == 2'b00) begin  // BEQ, BNE
            dec.uop   = funct3[0] ? BR_NE : BR_EQ;
            dec.opr_b = rs2_fwd;
            dec.opr_c = s1_data.pc + imm_b;
        end
        default: ;
    endcase
end

assign s2_stall = s2_valid && s2_busy;
assign s1_busy  = s2_stall || s1_bubble;   // Hold fetch word on a bubble

always_ff @(posedge g_clk) begin
    if (rst || flush) begin
        s2_valid <= 1'b0;
    end else if (!s2_stall) begin
        s2_valid <= s1_valid && !s1_bubble;
    end
end

always_ff @(posedge g_clk) begin
    if (!s2_stall) s2_data <= dec;
end

endmodule

/* pipeline/frv_execute.sv */
/*
 * Single-cycle ALU and branch compare. Loads and stores only form
 * their address here. Branch targets are precomputed in decode.
 */
`timescale 1ns/10ps

module frv_execute import frv_pkg::*; (
    input  logic    g_clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    s2_valid,
    input  decode_t s2_data,
    input  logic    s3_busy,
    output logic    s2_busy,
    output fwd_t    fwd_s2,
    output logic    s3_valid,
    output exec_t   s3_data
);

word_t a, b;
word_t alu;
logic  taken;

assign a = s2_data.opr_a;
assign b = s2_data.opr_b;

always_comb begin
    case (s2_data.uop)
        ALU_SUB:      alu = a - b;
        ALU_AND:      alu = a & b;
        ALU_OR:       alu = a | b;
        ALU_XOR:      alu = a ^ b;
        BR_EQ, BR_NE: alu = s2_data.opr_c;   // Target
        default:      alu = a + b;           // ADD and addresses
    endcase
end

assign taken = (s2_data.uop == BR_EQ && a == b) ||
               (s2_data.uop == BR_NE && a != b);

assign s2_busy = s3_valid && s3_busy;
assign fwd_s2  = '{valid: s2_valid, rd: s2_data.rd, wdata: alu,
                   is_load: s2_data.uop == LOAD};

always_ff @(posedge g_clk) begin
    if (rst || flush) begin
        s3_valid <= 1'b0;
    end else if (!s2_busy) begin
        s3_valid <= s2_valid;
    end
end

always_ff @(posedge g_clk) begin
    if (!s2_busy) begin
        s3_data <= '{pc: s2_data.pc, instr: s2_data.instr, uop: s2_data.uop,
                     rd: s2_data.rd, result: alu, store_data: s2_data.opr_c,
                     taken: taken};
    end
end

endmodule

/* pipeline/frv_memory.sv */
/*
 * Issues one word access per LW or SW and holds until gnt.
 * After a taken branch leaves for writeback, later instructions wait
 * here until the flush so no wrong-path store reaches the bus.
 */
`timescale 1ns/10ps

module frv_memory import frv_pkg::*; (
    input  logic     g_clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     s3_valid,
    input  exec_t    s3_data,
    input  logic     dmem_gnt,
    input  logic     s4_busy,
    output logic     s3_busy,
    output fwd_t     fwd_s3,
    output logic     dmem_req,
    output mem_req_t dmem_out,
    output logic     s4_valid,
    output exec_t    s4_data
);

logic is_mem;                       // Valid load or store
logic shadow;                       // Behind a taken branch
logic stall;
logic go;                           // Moves to writeback

assign is_mem   = s3_valid && (s3_data.uop == LOAD || s3_data.uop == STORE);
assign dmem_req = is_mem && !shadow && !s4_busy;
assign dmem_out = '{wen: s3_data.uop == STORE, strb: 4'hf,
                    addr: s3_data.result, wdata: s3_data.store_data};

assign stall   = shadow || s4_busy || (is_mem && !dmem_gnt);
assign s3_busy = s3_valid && stall;
assign go      = s3_valid && !stall;
assign fwd_s3  = '{valid: s3_valid, rd: s3_data.rd, wdata: s3_data.result,
                   is_load: s3_data.uop == LOAD};

always_ff @(posedge g_clk) begin
    if (rst || flush) begin
        s4_valid <= 1'b0;
        shadow   <= 1'b0;
    end else begin
        if (!s4_busy) s4_valid <= go;
        if (go && s3_data.taken) shadow <= 1'b1;
    end
end

always_ff @(posedge g_clk) begin
    if (go) s4_data <= s3_data;
end

// Load/store request frozen until accepted
assert property (@(posedge g_clk) disable iff (rst)
    dmem_req && !dmem_gnt |=> dmem_req && $stable(dmem_out));

endmodule

/* pipeline/frv_writeback.sv */
/*
 * Retires one instruction per valid cycle and never stalls.
 * Load data is taken straight off dmem_rdata. A taken branch raises
 * cf_req on the next cycle and holds it until fetch acknowledges.
 */
`timescale 1ns/10ps

module frv_writeback import frv_pkg::*; (
    input  logic      g_clk,
    input  logic      rst,
    input  logic      s4_valid,
    input  exec_t     s4_data,
    input  word_t     dmem_rdata,
    input  logic      cf_ack,
    output logic      s4_busy,
    output fwd_t      fwd_s4,
    output logic      gpr_wen,
    output reg_addr_t gpr_rd,
    output word_t     gpr_wdata,
    output logic      cf_req,
    output word_t     cf_target,
    output logic      trs_valid,
    output trace_t    trs
);

word_t wdata;                       // Value written to rd

assign wdata     = (s4_data.uop == LOAD) ? dmem_rdata : s4_data.result;
assign s4_busy   = 1'b0;
assign gpr_wen   = s4_valid && |s4_data.rd;
assign gpr_rd    = s4_data.rd;
assign gpr_wdata = wdata;
assign fwd_s4    = '{valid: s4_valid, rd: s4_data.rd, wdata: wdata, is_load: 1'b0};

always_ff @(posedge g_clk) begin
    if (rst) begin
        cf_req    <= 1'b0;
        trs_valid <= 1'b0;
    end else begin
        trs_valid <= s4_valid;
        if (s4_valid && s4_data.taken) begin
            cf_req <= 1'b1;
        end else if (cf_ack) begin
            cf_req <= 1'b0;                  // Redirect taken by fetch
        end
    end
end

always_ff @(posedge g_clk) begin
    if (s4_valid && s4_data.taken) cf_target <= s4_data.result;
    if (s4_valid) begin
        trs <= '{pc: s4_data.pc, instr: s4_data.instr, rd: s4_data.rd,
                 wdata: |s4_data.rd ? wdata : '0};
    end
end

endmodule

/* rtl/frv_pipeline.sv */
/*
 * Five-stage RV32 subset core: ADD SUB AND OR XOR ADDI LUI LW SW BEQ BNE.
 * Word accesses only. Both buses return read data one cycle after gnt.
 * No traps; unknown opcodes retire as nops.
 */
`timescale 1ns/10ps

module frv_pipeline import frv_pkg::*; (
    input  logic     g_clk,
    input  logic     rst,
    output logic     imem_req,
    output mem_req_t imem_out,
    input  logic     imem_gnt,
    input  word_t    imem_rdata,
    output logic     dmem_req,
    output mem_req_t dmem_out,
    input  logic     dmem_gnt,
    input  word_t    dmem_rdata,
    output logic     trs_valid,
    output trace_t   trs
);

// ----------------------------------------
// Control flow and stage links

logic      cf_req, cf_ack;          // Redirect handshake
word_t     cf_target;
logic      flush;                   // Kills fetch to memory

logic      s1_valid, s1_busy, s1_bubble;
fetch_t    s1_data;
logic      s2_valid, s2_busy;
decode_t   s2_data;
logic      s3_valid, s3_busy;
exec_t     s3_data;
logic      s4_valid, s4_busy;
exec_t     s4_data;

// ----------------------------------------
// Register file and forwarding

reg_addr_t rs1_addr, rs2_addr;
word_t     rs1_data, rs2_data;      // Raw GPR reads
word_t     rs1_fwd, rs2_fwd;        // After forwarding
fwd_t      fwd_s2, fwd_s3, fwd_s4;
logic      gpr_wen;
reg_addr_t gpr_rd;
word_t     gpr_wdata;

assign flush = cf_req && cf_ack;

frv_fetch     u_fetch     (.*);
frv_decode    u_decode    (.*);
frv_execute   u_execute   (.*);
frv_memory    u_memory    (.*);
frv_writeback u_writeback (.*);
frv_hazard    u_hazard    (.*);

frv_gprs u_gprs (
    .g_clk    (g_clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_wen   (gpr_wen),
    .rd_addr  (gpr_rd),
    .rd_wdata (gpr_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

endmodule

/* sim/tb_clock.sv */
/*
 * Clock and reset source for the testbench. Reset is synchronous and
 * active high, released by a nonblocking update on a rising edge.
 */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD     = 20,  // ns
    parameter int RST_CYCLES = 3
) (
    output logic g_clk,
    output logic rst
);

initial begin
    g_clk = 1'b0;
    forever #(PERIOD / 2) g_clk = ~g_clk;
end

initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge g_clk);
    rst <= 1'b0;                    // Low from the third edge on
end

endmodule

/* sim/tb_frv_pipeline.sv */
/*
 * Random program testbench. Only x0..x7 are used, loads and stores
 * address off x0 in 0..252, branches only skip forward 2 to 4 slots.
 * An in-order model runs the program ahead and the trace is compared.
 */
`timescale 1ns/10ps
`include "frv_settings.svh"

module tb_frv_pipeline import frv_pkg::*; ();

localparam int          N_CHECK  = 150;            // Retirements compared
localparam int          N_MODEL  = 170;            // Model runs past the checked ones
localparam int          N_RANDOM = 200;            // Random slots, NOPs after
localparam int          TIMEOUT  = 400;            // Cycles allowed per wait
localparam logic [31:0] NOP      = 32'h0000_0013;  // ADDI x0, x0, 0

logic     g_clk, rst;
logic     imem_req, imem_gnt;
mem_req_t imem_out;
word_t    imem_rdata;
logic     dmem_req, dmem_gnt;
mem_req_t dmem_out;
word_t    dmem_rdata;
logic     trs_valid;
trace_t   trs;

integer   seed;
word_t    gnt_bits;
word_t    prog  [0:255];            // Instruction memory
word_t    dmem  [0:63];             // Data memory behind the bus
word_t    mmem  [0:63];             // Model's data memory
word_t    mregs [0:31];             // Model's GPRs
trace_t   exp_trace [$];
word_t    st_addr_q [$];
word_t    st_data_q [$];
word_t    exp_addr, exp_data;
int       store_need;               // Stores within the checked window
int       stores_seen;
logic     first_seen;               // First imem grant already checked

tb_clock u_clock (
    .g_clk (g_clk),
    .rst   (rst)
);

frv_pipeline u_frv_pipeline (
    .g_clk      (g_clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_out   (imem_out),
    .imem_gnt   (imem_gnt),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_out   (dmem_out),
    .dmem_gnt   (dmem_gnt),
    .dmem_rdata (dmem_rdata),
    .trs_valid  (trs_valid),
    .trs        (trs)
);

// ----------------------------------------
// Failure reporting and compare

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
endtask

task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        report_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
endtask

// ----------------------------------------
// Program generation

function automatic word_t rand_word();
    return $random(seed);
endfunction

function automatic reg_addr_t pick_reg();
    word_t r;
    r = rand_word();
    return {2'b00, r[2:0]};             // x0..x7 keeps hazards frequent
endfunction

function automatic word_t alu_reg_op(input logic [2:0] sel, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (sel == 3'd1) ? 7'h20 : 7'h00;  // SUB
    case (sel)
        3'd2:    f3 = 3'h4;             // XOR
        3'd3:    f3 = 3'h6;             // OR
        3'd4:    f3 = 3'h7;             // AND
        default: f3 = 3'h0;             // ADD, SUB
    endcase
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic word_t imm_op(input logic [11:0] imm, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd,
                                 input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t store_op(input logic [11:0] imm, input reg_addr_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'h2, imm[4:0], 7'h23};  // SW rs2, imm(x0)
endfunction

function automatic word_t branch_op(input logic [12:0] off, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic ne);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'h63};
endfunction

task automatic build_program();
    word_t     r;
    reg_addr_t rd, ra, rb;
    for (int i = 0; i < 256; i++) begin
        prog[i] = NOP;                  // Tail of the program
    end
    for (int i = 0; i < 64; i++) begin
        dmem[i] = (word_t'(i * 4) * 32'h9e37_79b9) ^ 32'h0bad_f00d;
        mmem[i] = dmem[i];
    end
    for (int i = 1; i < 8; i++) begin
        r = rand_word();
        prog[i - 1] = imm_op(r[11:0], 5'd0, 3'h0, 5'(i), 7'h13);  // Give x1..x7 a value
    end
    for (int i = 7; i < N_RANDOM; i++) begin
        r  = rand_word();
        rd = pick_reg();
        ra = pick_reg();
        rb = pick_reg();
        case (r % 10)
            0, 1, 2, 3: prog[i] = alu_reg_op(3'(r[31:8] % 5), rd, ra, rb);
            4:          prog[i] = imm_op(r[19:8], ra, 3'h0, rd, 7'h13);        // ADDI
            5:          prog[i] = {r[31:12], rd, 7'h37};                       // LUI
            6:          prog[i] = imm_op({4'h0, r[13:8], 2'b00}, 5'd0, 3'h2, rd, 7'h03);
            7:          prog[i] = store_op({4'h0, r[13:8], 2'b00}, rb);
            default:    prog[i] = branch_op(13'(4 * (r[31:8] % 3 + 2)), ra, rb, r[4]);
        endcase
    end
endtask

// ----------------------------------------
// Instruction-set model

task automatic run_model();
    word_t     pc, ins, a, b, val, addr, next_pc;
    reg_addr_t rd;
    trace_t    t;
    for (int i = 0; i < 32; i++) begin
        mregs[i] = '0;
    end
    pc         = `FRV_PC_RESET;
    store_need = 0;
    for (int n = 0; n < N_MODEL; n++) begin
        ins     = prog[pc[9:2]];
        a       = mregs[ins[19:15]];
        b       = mregs[ins[24:20]];
        rd      = '0;                   // Stores and branches write nothing
        val     = '0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                rd = ins[11:7];
                case (ins[14:12])
                    3'h4:    val = a ^ b;
                    3'h6:    val = a | b;
                    3'h7:    val = a & b;
                    default: val = ins[30] ? a - b : a + b;
                endcase
            end
            7'h13: begin
                rd  = ins[11:7];
                val = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'h37: begin
                rd  = ins[11:7];
                val = {ins[31:12], 12'h000};
            end
            7'h03: begin
                rd   = ins[11:7];
                addr = a + {{20{ins[31]}}, ins[31:20]};
                val  = mmem[addr[7:2]];
            end
            7'h23: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mmem[addr[7:2]] = b;
                st_addr_q.push_back(addr);
                st_data_q.push_back(b);
                if (n < N_CHECK) store_need++;
            end
            7'h63: begin
                if ((ins[12] == 1'b0) == (a == b)) begin  // BEQ equal or BNE unequal
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        if (rd != '0) begin
            mregs[rd] = val;
        end else begin
            val = '0;                   // Trace shows zero for x0
        end
        t = '{pc: pc, instr: ins, rd: rd, wdata: val};
        exp_trace.push_back(t);
        pc = next_pc;
    end
endtask

// ----------------------------------------
// Bus models, driven on the rising edge

always @(posedge g_clk) begin
    gnt_bits = rand_word();
    imem_gnt <= gnt_bits[0];            // Granted about half the time
    dmem_gnt <= gnt_bits[1];
    if (imem_req && imem_gnt) begin
        imem_rdata <= prog[imem_out.addr[9:2]];  // Data one cycle after gnt
    end
    if (dmem_req && dmem_gnt) begin
        if (dmem_out.wen) begin
            dmem[dmem_out.addr[7:2]] <= dmem_out.wdata;
        end else begin
            dmem_rdata <= dmem[dmem_out.addr[7:2]];
        end
    end
end

// Bus monitors, sampled mid-cycle
always @(negedge g_clk) begin
    if (!rst && !first_seen && imem_req && imem_gnt) begin
        check("imem_out.addr", imem_out.addr, `FRV_PC_RESET);
        first_seen = 1'b1;
    end
    if (!rst && dmem_req && dmem_gnt && dmem_out.wen) begin
        if (st_addr_q.size() == 0) begin
            report_failure("A store reached the data bus after the model ran out of stores");
        end else begin
            exp_addr = st_addr_q.pop_front();
            exp_data = st_data_q.pop_front();
            check("dmem_out.addr", dmem_out.addr, exp_addr);
            check("dmem_out.wdata", dmem_out.wdata, exp_data);
            check("dmem_out.strb", {28'h0, dmem_out.strb}, 32'h0000_000f);
            stores_seen++;
        end
    end
end

task automatic wait_retire(input int idx);
    int cycles;
    cycles = 0;
    do begin
        @(negedge g_clk);
        cycles++;
    end while (!trs_valid && cycles < TIMEOUT);
    if (!trs_valid) begin
        report_failure($sformatf("Instruction %0d did not retire within %0d cycles",
                                 idx, TIMEOUT));
    end
endtask

// ----------------------------------------
// Main sequence

initial begin
    int     cycles;
    trace_t e;
    seed        = 32'hc83110b3;
    imem_gnt    = 1'b0;
    imem_rdata  = '0;
    dmem_gnt    = 1'b0;
    dmem_rdata  = '0;
    first_seen  = 1'b0;
    stores_seen = 0;
    build_program();
    run_model();

    // Outputs quiet in reset and on the first cycle out of it
    cycles = 0;
    do begin
        @(negedge g_clk);
        check("trs_valid", {31'h0, trs_valid}, 32'h0);
        check("dmem_req", {31'h0, dmem_req}, 32'h0);
        check("imem_req", {31'h0, imem_req}, 32'h0);
        cycles++;
    end while (rst && cycles < 10);
    if (rst) report_failure("Reset was still asserted after 10 cycles");

    for (int i = 0; i < N_CHECK; i++) begin
        wait_retire(i);
        e = exp_trace[i];
        check("trs.pc", trs.pc, e.pc);
        check("trs.instr", trs.instr, e.instr);
        check("trs.rd", {27'h0, trs.rd}, {27'h0, e.rd});
        check("trs.wdata", trs.wdata, e.wdata);
    end

    if (stores_seen < store_need) begin
        report_failure($sformatf("Only %0d of %0d expected stores reached the data bus",
                                 stores_seen, store_need));
    end else begin
        $display("All checks passed");
        $finish;
    end
end

endmodule

/* verilog.f */
+incdir+common
common/frv_pkg.sv
rtl/frv_gprs.sv
rtl/frv_hazard.sv
pipeline/frv_fetch.sv
pipeline/frv_decode.sv
pipeline/frv_execute.sv
pipeline/frv_memory.sv
pipeline/frv_writeback.sv
rtl/frv_pipeline.sv
sim/tb_clock.sv
sim/tb_frv_pipeline.sv

/* run.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_frv_pipeline \
    -Mdir obj_dir -o tb_frv_pipeline
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_frv_pipeline > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation PASSED"
exit 0
